/* design/apb_timer_pkg.sv */
//////////////////////////////
// Shared widths, bridge states and register map
// for the APB timer
//////////////////////////////
package apb_timer_pkg;

   // Defaults for the top-level parameters
   localparam int APB_ADDR_W_DEF = 8;
   localparam int DATA_W_DEF     = 32;

   // Bridge sequencer, one APB transfer per pass
   typedef enum logic [1:0] {
      WAIT_ENABLE    = 2'd0,
      WAIT_READY     = 2'd1,
      RVALID         = 2'd2,
      WAIT_APB_READY = 2'd3
   } bridge_state_e;

   // Register word offsets
   typedef enum logic [7:0] {
      REG_CTRL   = 8'h00,  // enable, auto-reload
      REG_LOAD   = 8'h04,  // reload value
      REG_COUNT  = 8'h08,  // live count, read only
      REG_STATUS = 8'h0C   // sticky expired, write 1 to clear
   } reg_addr_e;

   // CTRL field positions
   localparam int CTRL_EN_BIT     = 0;
   localparam int CTRL_RELOAD_BIT = 1;

   // STATUS field position
   localparam int STAT_EXP_BIT = 0;

endpackage

/* design/apb2iob_bridge.sv */
//////////////////////////////
// APB subordinate to IOb manager bridge
//////////////////////////////
`timescale 1ns/1ps

module apb2iob_bridge #(
   parameter int ADDR_W = apb_timer_pkg::APB_ADDR_W_DEF,
   parameter int DATA_W = apb_timer_pkg::DATA_W_DEF
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   // APB subordinate side
   input  logic                  apb_sel_i,
   input  logic                  apb_enable_i,
   input  logic                  apb_write_i,
   input  logic [ADDR_W-1:0]     apb_addr_i,
   input  logic [DATA_W-1:0]     apb_wdata_i,
   input  logic [DATA_W/8-1:0]   apb_wstrb_i,
   output logic [DATA_W-1:0]     apb_rdata_o,
   output logic                  apb_ready_o,
   // IOb manager side
   output logic                  iob_valid_o,
   output logic [ADDR_W-1:0]     iob_addr_o,
   output logic [DATA_W-1:0]     iob_wdata_o,
   output logic [DATA_W/8-1:0]   iob_wstrb_o,
   output logic                  iob_rready_o,
   input  logic                  iob_ready_i,
   input  logic                  iob_rvalid_i,
   input  logic [DATA_W-1:0]     iob_rdata_i
);
   import apb_timer_pkg::*;

   localparam int WSTRB_W = DATA_W / 8;

   bridge_state_e state_q;
   bridge_state_e state_d;
   logic          iob_valid;
   logic          iob_rready;
   logic          apb_ready_d;

   assign iob_valid_o  = iob_valid;
   assign iob_addr_o   = apb_addr_i;
   assign iob_wdata_o  = apb_wdata_i;
   assign iob_wstrb_o  = apb_write_i ? apb_wstrb_i : {WSTRB_W{1'b0}};  // Zero strobe marks a read
   assign iob_rready_o = iob_rready;

   always_comb begin
      state_d     = state_q;
      iob_valid   = 1'b0;
      iob_rready  = 1'b0;
      apb_ready_d = 1'b0;
      case (state_q)
         WAIT_ENABLE: begin
            if (apb_sel_i && apb_enable_i) begin  // First access cycle
               iob_valid = 1'b1;
               state_d   = WAIT_READY;
            end
         end
         WAIT_READY: begin
            iob_valid = 1'b1;
            if (iob_ready_i) begin
               if (apb_write_i) begin
                  state_d     = WAIT_APB_READY;
                  apb_ready_d = 1'b1;
               end else begin
                  state_d = RVALID;
               end
            end
         end
         RVALID: begin
            iob_rready  = 1'b1;
            apb_ready_d = iob_rvalid_i;
            if (iob_rvalid_i) begin
               state_d = WAIT_APB_READY;
            end
         end
         default: begin
            state_d = WAIT_ENABLE;  // pready is out this cycle
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q     <= WAIT_ENABLE;
         apb_ready_o <= 1'b0;
      end else begin
         state_q     <= state_d;
         apb_ready_o <= apb_ready_d;
      end
   end

   // Read data held for the APB manager
   always_ff @(posedge clk_i) begin
      if (iob_rvalid_i) begin
         apb_rdata_o <= iob_rdata_i;
      end
   end

   // Ready ends the transfer, so it can't repeat back to back
   a_ready_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      apb_ready_o |=> !apb_ready_o);

   // No IOb request outside an APB transfer
   a_valid_in_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      iob_valid_o |-> apb_sel_i);

endmodule

/* design/timer_regs.sv */
//////////////////////////////
// IOb register block for the timer
// CTRL, LOAD, COUNT and STATUS
//////////////////////////////
`timescale 1ns/1ps

module timer_regs #(
   parameter int ADDR_W = apb_timer_pkg::APB_ADDR_W_DEF,
   parameter int DATA_W = apb_timer_pkg::DATA_W_DEF,
   parameter int CNT_W  = 16
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  iob_valid_i,
   input  logic [ADDR_W-1:0]     iob_addr_i,
   input  logic [DATA_W-1:0]     iob_wdata_i,
   input  logic [DATA_W/8-1:0]   iob_wstrb_i,
   input  logic                  iob_rready_i,
   output logic                  iob_ready_o,
   output logic                  iob_rvalid_o,
   output logic [DATA_W-1:0]     iob_rdata_o,
   input  logic [CNT_W-1:0]      count_value_i,
   input  logic                  expire_pulse_i,
   output logic                  cnt_en_o,
   output logic                  auto_reload_o,
   output logic                  load_pulse_o,
   output logic [CNT_W-1:0]      load_value_o,
   output logic                  expired_o
);
   import apb_timer_pkg::*;

   logic              ctrl_en_q;
   logic              ctrl_reload_q;
   logic [CNT_W-1:0]  load_q;
   logic              load_pulse_q;
   logic              expired_q;
   logic              rvalid_q;
   logic [DATA_W-1:0] rdata_q;
   logic [DATA_W-1:0] rdata_d;
   logic              wr_acc;
   logic              rd_acc;
   logic              sel_ctrl;
   logic              sel_load;
   logic              sel_status;

   assign iob_ready_o = 1'b1;  // Always accepts
   assign wr_acc      = iob_valid_i & iob_ready_o & (|iob_wstrb_i);
   assign rd_acc      = iob_valid_i & iob_ready_o & ~(|iob_wstrb_i);

   assign sel_ctrl   = (iob_addr_i == ADDR_W'(REG_CTRL));
   assign sel_load   = (iob_addr_i == ADDR_W'(REG_LOAD));
   assign sel_status = (iob_addr_i == ADDR_W'(REG_STATUS));

   always_comb begin
      rdata_d = '0;  // Unmapped reads as zero
      case (iob_addr_i)
         ADDR_W'(REG_CTRL): begin
            rdata_d[CTRL_EN_BIT]     = ctrl_en_q;
            rdata_d[CTRL_RELOAD_BIT] = ctrl_reload_q;
         end
         ADDR_W'(REG_LOAD):   rdata_d[CNT_W-1:0] = load_q;
         ADDR_W'(REG_COUNT):  rdata_d[CNT_W-1:0] = count_value_i;
         ADDR_W'(REG_STATUS): rdata_d[STAT_EXP_BIT] = expired_q;
         default: ;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ctrl_en_q     <= 1'b0;
         ctrl_reload_q <= 1'b0;
         load_q        <= '0;
         load_pulse_q  <= 1'b0;
         expired_q     <= 1'b0;
         rvalid_q      <= 1'b0;
      end else begin
         // Pulse once although the bridge repeats a write for two cycles
         load_pulse_q <= wr_acc & sel_load & ~load_pulse_q;
         if (wr_acc && sel_ctrl && iob_wstrb_i[0]) begin
            ctrl_en_q     <= iob_wdata_i[CTRL_EN_BIT];
            ctrl_reload_q <= iob_wdata_i[CTRL_RELOAD_BIT];
         end
         if (wr_acc && sel_load) begin
            for (int b = 0; b < CNT_W; b++) begin
               if (iob_wstrb_i[b/8]) begin
                  load_q[b] <= iob_wdata_i[b];
               end
            end
         end
         if (expire_pulse_i) begin
            expired_q <= 1'b1;  // Set beats clear
         end else if (wr_acc && sel_status && iob_wstrb_i[0] && iob_wdata_i[STAT_EXP_BIT]) begin
            expired_q <= 1'b0;
         end
         rvalid_q <= rd_acc | (rvalid_q & ~iob_rready_i);  // Hold until taken
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_acc) begin
         rdata_q <= rdata_d;
      end
   end

   assign iob_rvalid_o  = rvalid_q;
   assign iob_rdata_o   = rdata_q;
   assign cnt_en_o      = ctrl_en_q;
   assign auto_reload_o = ctrl_reload_q;
   assign load_pulse_o  = load_pulse_q;
   assign load_value_o  = load_q;
   assign expired_o     = expired_q;

   // Response only in the cycle after an accepted read
   a_rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      iob_rvalid_o |-> $past(rd_acc));

   a_load_pulse_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      load_pulse_o |=> !load_pulse_o);

endmodule

/* design/timer_core.sv */
//////////////////////////////
// Down-counter with reload and expiry pulse
//////////////////////////////
`timescale 1ns/1ps

module timer_core #(
   parameter int CNT_W = 16
) (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic             cnt_en_i,
   input  logic             auto_reload_i,
   input  logic             load_pulse_i,
   input  logic [CNT_W-1:0] load_value_i,
   output logic [CNT_W-1:0] count_value_o,
   output logic             expire_pulse_o
);
   logic [CNT_W-1:0] count_q;
   logic [CNT_W-1:0] reload_q;
   logic             stopped_q;  // One-shot already fired
   logic             at_zero;

   assign at_zero        = (count_q == '0);
   assign expire_pulse_o = cnt_en_i & at_zero & (auto_reload_i | ~stopped_q);
   assign count_value_o  = count_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         count_q   <= '0;
         reload_q  <= '0;
         stopped_q <= 1'b0;
      end else if (load_pulse_i) begin  // Load wins over counting
         count_q   <= load_value_i;
         reload_q  <= load_value_i;
         stopped_q <= 1'b0;
      end else if (cnt_en_i) begin
         if (!at_zero) begin
            count_q <= count_q - 1'b1;
         end else if (expire_pulse_o) begin
            if (auto_reload_i) begin
               count_q <= reload_q;
            end else begin
               stopped_q <= 1'b1;  // Park at zero
            end
         end
      end
   end

   a_expire_at_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      expire_pulse_o |-> count_value_o == '0);

endmodule

/* design/apb_timer_top.sv */
//////////////////////////////
// APB timer top level
//////////////////////////////
`timescale 1ns/1ps

module apb_timer_top #(
   parameter int ADDR_W = apb_timer_pkg::APB_ADDR_W_DEF,
   parameter int DATA_W = apb_timer_pkg::DATA_W_DEF,
   parameter int CNT_W  = 16
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                apb_sel_i,
   input  logic                apb_enable_i,
   input  logic                apb_write_i,
   input  logic [ADDR_W-1:0]   apb_addr_i,
   input  logic [DATA_W-1:0]   apb_wdata_i,
   input  logic [DATA_W/8-1:0] apb_wstrb_i,
   output logic [DATA_W-1:0]   apb_rdata_o,
   output logic                apb_ready_o,
   output logic                timer_expired_o
);
   logic                iob_valid;
   logic [ADDR_W-1:0]   iob_addr;
   logic [DATA_W-1:0]   iob_wdata;
   logic [DATA_W/8-1:0] iob_wstrb;
   logic                iob_rready;
   logic                iob_ready;
   logic                iob_rvalid;
   logic [DATA_W-1:0]   iob_rdata;
   logic                cnt_en;
   logic                auto_reload;
   logic                load_pulse;
   logic [CNT_W-1:0]    load_value;
   logic [CNT_W-1:0]    count_value;
   logic                expire_pulse;

   apb2iob_bridge #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) apb2iob_bridge_inst (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .apb_sel_i   (apb_sel_i),
      .apb_enable_i(apb_enable_i),
      .apb_write_i (apb_write_i),
      .apb_addr_i  (apb_addr_i),
      .apb_wdata_i (apb_wdata_i),
      .apb_wstrb_i (apb_wstrb_i),
      .apb_rdata_o (apb_rdata_o),
      .apb_ready_o (apb_ready_o),
      .iob_valid_o (iob_valid),
      .iob_addr_o  (iob_addr),
      .iob_wdata_o (iob_wdata),
      .iob_wstrb_o (iob_wstrb),
      .iob_rready_o(iob_rready),
      .iob_ready_i (iob_ready),
      .iob_rvalid_i(iob_rvalid),
      .iob_rdata_i (iob_rdata)
   );

   timer_regs #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W),
      .CNT_W (CNT_W)
   ) timer_regs_inst (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .iob_valid_i   (iob_valid),
      .iob_addr_i    (iob_addr),
      .iob_wdata_i   (iob_wdata),
      .iob_wstrb_i   (iob_wstrb),
      .iob_rready_i  (iob_rready),
      .iob_ready_o   (iob_ready),
      .iob_rvalid_o  (iob_rvalid),
      .iob_rdata_o   (iob_rdata),
      .count_value_i (count_value),
      .expire_pulse_i(expire_pulse),
      .cnt_en_o      (cnt_en),
      .auto_reload_o (auto_reload),
      .load_pulse_o  (load_pulse),
      .load_value_o  (load_value),
      .expired_o     (timer_expired_o)
   );

   timer_core #(
      .CNT_W(CNT_W)
   ) timer_core_inst (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cnt_en_i      (cnt_en),
      .auto_reload_i (auto_reload),
      .load_pulse_i  (load_pulse),
      .load_value_i  (load_value),
      .count_value_o (count_value),
      .expire_pulse_o(expire_pulse)
   );

endmodule

/* sim/tb_apb_timer.sv */
//////////////////////////////
// APB timer testbench with LFSR stimulus,
// APB driver tasks, register model and checks
//////////////////////////////
`timescale 1ns/1ps

module tb_apb_timer;
   import apb_timer_pkg::*;

   localparam int ADDR_W      = APB_ADDR_W_DEF;
   localparam int DATA_W      = DATA_W_DEF;
   localparam int CNT_W       = 16;
   localparam int WR_CYCLES   = 3;   // Access phase of a write
   localparam int RD_CYCLES   = 4;
   localparam int READY_LIMIT = 20;

   logic                clk_i = 1'b0;
   logic                rst_n_i;
   logic                apb_sel_i;
   logic                apb_enable_i;
   logic                apb_write_i;
   logic [ADDR_W-1:0]   apb_addr_i;
   logic [DATA_W-1:0]   apb_wdata_i;
   logic [DATA_W/8-1:0] apb_wstrb_i;
   logic [DATA_W-1:0]   apb_rdata_o;
   logic                apb_ready_o;
   logic                timer_expired_o;

   logic [31:0]      lfsr_q    = 32'h4237_cf76;
   int               errors    = 0;
   int               checks    = 0;
   int               cycle_cnt = 0;
   logic [1:0]       model_ctrl;
   logic [CNT_W-1:0] model_load;
   logic             model_expired;

   apb_timer_top apb_timer_top_inst (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .apb_sel_i      (apb_sel_i),
      .apb_enable_i   (apb_enable_i),
      .apb_write_i    (apb_write_i),
      .apb_addr_i     (apb_addr_i),
      .apb_wdata_i    (apb_wdata_i),
      .apb_wstrb_i    (apb_wstrb_i),
      .apb_rdata_o    (apb_rdata_o),
      .apb_ready_o    (apb_ready_o),
      .timer_expired_o(timer_expired_o)
   );

   always #5 clk_i = ~clk_i;

   always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

   // Ready only shows up inside a transfer
   always @(posedge clk_i) begin
      if (rst_n_i && !apb_sel_i) begin
         assert (!apb_ready_o) else begin
            $display("apb_ready_o was high outside an APB transfer at cycle %0d", cycle_cnt);
            errors++;
         end
      end
   end

   // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         val    = {val[30:0], fb};
      end
      return val;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      assert (actual === expected) else begin
         $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   // Counts edges from the first access cycle until ready is seen
   task automatic wait_ready(input string name, input int expected_cycles);
      int n;
      n = 0;
      do begin
         @(posedge clk_i);
         n++;
      end while (!apb_ready_o && n < READY_LIMIT);
      if (!apb_ready_o) begin
         $display("Timeout: %s got no apb_ready_o within %0d cycles", name, READY_LIMIT);
         errors++;
      end else begin
         check_value({name, " timing"}, expected_cycles, n);
      end
      apb_sel_i    <= 1'b0;  // Transfer ends at this edge
      apb_enable_i <= 1'b0;
      apb_write_i  <= 1'b0;
   endtask

   task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [DATA_W/8-1:0] strb);
      @(posedge clk_i);
      apb_sel_i   <= 1'b1;  // Setup phase
      apb_write_i <= 1'b1;
      apb_addr_i  <= addr;
      apb_wdata_i <= data;
      apb_wstrb_i <= strb;
      @(posedge clk_i);
      apb_enable_i <= 1'b1;
      wait_ready("write", WR_CYCLES);
   endtask

   task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
      @(posedge clk_i);
      apb_sel_i   <= 1'b1;
      apb_write_i <= 1'b0;
      apb_addr_i  <= addr;
      apb_wdata_i <= '0;
      apb_wstrb_i <= '1;  // Bridge masks these on reads
      @(posedge clk_i);
      apb_enable_i <= 1'b1;
      wait_ready("read", RD_CYCLES);
      data = apb_rdata_o;
   endtask

   // Reads STATUS until the expired flag is set or the limit runs out
   task automatic poll_expired(input string name, input int limit);
      logic [31:0] status;
      int          start;
      status = '0;
      start  = cycle_cnt;
      while (!status[STAT_EXP_BIT] && (cycle_cnt - start) < limit) begin
         apb_read(REG_STATUS, status);
      end
      checks++;
      assert (status[STAT_EXP_BIT]) else begin
         $display("Timeout: %s expired flag not set within %0d cycles", name, limit);
         errors++;
      end
   endtask

   initial begin
      logic [31:0] data;
      logic [31:0] rdata;
      logic [31:0] mask;
      logic [3:0]  strb;
      logic [7:0]  addr;
      int          n_load;
      rst_n_i       = 1'b0;
      apb_sel_i     = 1'b0;
      apb_enable_i  = 1'b0;
      apb_write_i   = 1'b0;
      apb_addr_i    = '0;
      apb_wdata_i   = '0;
      apb_wstrb_i   = '0;
      model_ctrl    = '0;
      model_load    = '0;
      model_expired = 1'b0;
      repeat (3) @(posedge clk_i);
      rst_n_i <= 1'b1;

      // Readback of CTRL and LOAD with random strobes and enable held low
      for (int i = 0; i < 16; i++) begin
         data = rand_bits(32);
         strb = 4'(rand_bits(4));
         if (strb == 4'h0) begin
            strb = 4'h1;
         end
         if (rand_bits(1) != 0) begin
            data[CTRL_EN_BIT] = 1'b0;
            apb_write(REG_CTRL, data, strb);
            if (strb[0]) begin
               model_ctrl = data[1:0];
            end
            apb_read(REG_CTRL, rdata);
            check_value("ctrl readback", 32'(model_ctrl), rdata);
         end else begin
            apb_write(REG_LOAD, data, strb);
            mask       = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
            model_load = CNT_W'((32'(model_load) & ~mask) | (data & mask));
            apb_read(REG_LOAD, rdata);
            check_value("load readback", 32'(model_load), rdata);
         end
      end

      // Bit 4 keeps unmapped offsets off the register map
      for (int i = 0; i < 8; i++) begin
         addr = 8'(rand_bits(8)) | 8'h10;
         apb_read(addr, rdata);
         check_value("unmapped read", 32'h0, rdata);
      end
      apb_read(REG_COUNT, rdata);
      check_value("count before write", 32'(model_load), rdata);
      apb_write(REG_COUNT, rand_bits(32), 4'hF);
      apb_read(REG_COUNT, rdata);
      check_value("count after write", 32'(model_load), rdata);

      // One-shot expiry
      n_load     = 20 + int'(rand_bits(5));
      model_load = CNT_W'(n_load);
      apb_write(REG_LOAD, n_load, 4'hF);
      model_ctrl = 2'b01;
      apb_write(REG_CTRL, 32'h1, 4'hF);
      poll_expired("one-shot", n_load + 50);
      model_expired = 1'b1;
      apb_read(REG_COUNT, rdata);
      check_value("one-shot count", 32'h0, rdata);
      @(posedge clk_i);
      check_value("one-shot expired_o", 32'(model_expired), 32'(timer_expired_o));

      // Clear and then auto-reload with a small value
      model_ctrl = 2'b10;
      apb_write(REG_CTRL, 32'h2, 4'hF);
      apb_write(REG_STATUS, 32'h1, 4'h1);
      model_expired = 1'b0;
      @(posedge clk_i);
      check_value("clear expired_o", 32'(model_expired), 32'(timer_expired_o));
      apb_read(REG_STATUS, rdata);
      check_value("clear status", 32'(model_expired), rdata);
      n_load     = 3 + int'(rand_bits(3));
      model_load = CNT_W'(n_load);
      apb_write(REG_LOAD, n_load, 4'hF);
      model_ctrl = 2'b11;
      apb_write(REG_CTRL, 32'h3, 4'hF);
      poll_expired("reload", n_load + 50);
      model_expired = 1'b1;
      apb_read(REG_COUNT, rdata);
      checks++;
      assert (rdata <= 32'(model_load)) else begin
         $display("[ERROR] reload count: expected at most %h, actual %h", model_load, rdata);
         errors++;
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

/* tb.f */
design/apb_timer_pkg.sv
design/apb2iob_bridge.sv
design/timer_regs.sv
design/timer_core.sv
design/apb_timer_top.sv
sim/tb_apb_timer.sv

/* Bender.yml */
package:
  name: apb_timer

dependencies: {}

sources:
  - files:
      - design/apb_timer_pkg.sv
      - design/apb2iob_bridge.sv
      - design/timer_regs.sv
      - design/timer_core.sv
      - design/apb_timer_top.sv
  - target: simulation
    files:
      - sim/tb_apb_timer.sv
